/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_MSG ?= TESTBENCH FAILED
VFLAGS ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f list.f --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
logic/mem_stage_pkg.sv
logic/access_issue.sv
logic/load_tracker.sv
logic/load_align.sv
logic/mem_stage.sv
testbench/tb_clock.sv
testbench/tb_memory.sv
testbench/mem_stage_sva.sv
testbench/tb_top.sv

/* logic/access_issue.sv */
`default_nettype none

module access_issue
  import mem_stage_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      cmd_valid,
  input  wire mem_cmd_t  cmd,
  output logic           req_valid,
  output mem_req_t       req,
  output logic           push_valid,
  output load_ctx_t      push_ctx
);

  logic       is_load;
  logic       is_store;
  logic [1:0] size_log2; // 0 byte, 1 half, 2 word, 3 double
  lane_t      lane;
  byte_mask_t size_mask;
  xlen_t      trimmed_data;

  always_comb begin
    is_load = 1'b0;
    is_store = 1'b0;
    size_log2 = 2'd0;
    case (cmd.op)
      op_lb, op_lbu: begin
        is_load = 1'b1;
      end
      op_lh, op_lhu: begin
        is_load = 1'b1;
        size_log2 = 2'd1;
      end
      op_lw, op_lwu: begin
        is_load = 1'b1;
        size_log2 = 2'd2;
      end
      op_ld: begin
        is_load = 1'b1;
        size_log2 = 2'd3;
      end
      op_sb: is_store = 1'b1;
      op_sh: begin
        is_store = 1'b1;
        size_log2 = 2'd1;
      end
      op_sw: begin
        is_store = 1'b1;
        size_log2 = 2'd2;
      end
      op_sd: begin
        is_store = 1'b1;
        size_log2 = 2'd3;
      end
      default: ;
    endcase
  end

  // Natural alignment, low offset bits dropped
  always_comb begin
    case (size_log2)
      2'd0: begin
        lane = cmd.addr[2:0];
        size_mask = 8'h01;
        trimmed_data = {56'd0, cmd.store_data[7:0]};
      end
      2'd1: begin
        lane = {cmd.addr[2:1], 1'b0};
        size_mask = 8'h03;
        trimmed_data = {48'd0, cmd.store_data[15:0]};
      end
      2'd2: begin
        lane = {cmd.addr[2], 2'b00};
        size_mask = 8'h0f;
        trimmed_data = {32'd0, cmd.store_data[31:0]};
      end
      default: begin
        lane = 3'b000;
        size_mask = 8'hff;
        trimmed_data = cmd.store_data;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req_valid <= 1'b0;
      push_valid <= 1'b0;
    end else begin
      req_valid <= cmd_valid && (is_load || is_store);
      push_valid <= cmd_valid && is_load;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      req.addr <= {cmd.addr[ADDR_W-1:3], 3'b000};
      req.write <= is_store;
      req.wmask <= is_store ? byte_mask_t'(size_mask << lane) : '0;
      req.wdata <= is_store ? xlen_t'(trimmed_data << {lane, 3'b000}) : '0;
      push_ctx.op <= cmd.op;
      push_ctx.lane <= lane;
      push_ctx.rd <= cmd.rd;
    end
  end

endmodule

`default_nettype wire

/* logic/load_align.sv */
`default_nettype none

module load_align
  import mem_stage_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      align_valid,
  input  wire load_ctx_t align_ctx,
  input  wire xlen_t     align_data,
  output logic           wb_valid,
  output wb_t            wb
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;
  logic [31:0] word_sel;
  xlen_t       value;

  // Lane bits below the access size are ignored
  assign byte_sel = align_data[{align_ctx.lane, 3'b000} +: 8];
  assign half_sel = align_data[{align_ctx.lane[2:1], 4'b0000} +: 16];
  assign word_sel = align_data[{align_ctx.lane[2], 5'b00000} +: 32];

  always_comb begin
    case (align_ctx.op)
      op_lb:   value = {{56{byte_sel[7]}}, byte_sel};
      op_lbu:  value = {56'd0, byte_sel};
      op_lh:   value = {{48{half_sel[15]}}, half_sel};
      op_lhu:  value = {48'd0, half_sel};
      op_lw:   value = {{32{word_sel[31]}}, word_sel};
      op_lwu:  value = {32'd0, word_sel};
      default: value = align_data; // ld
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= align_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (align_valid) begin
      wb.rd <= align_ctx.rd;
      wb.data <= value;
    end
  end

endmodule

`default_nettype wire

/* logic/load_tracker.sv */
`default_nettype none

module load_tracker
  import mem_stage_pkg::*;
#(
  parameter int PENDING_DEPTH = 4
) (
  input  wire logic      clk,
  input  wire logic      reset,
  input  wire logic      push_valid,
  input  wire load_ctx_t push_ctx,
  input  wire logic      flush,
  input  wire logic      resp_valid,
  input  wire xlen_t     resp_data,
  output logic           align_valid,
  output load_ctx_t      align_ctx,
  output xlen_t          align_data
);

  localparam int PTR_W = $clog2(PENDING_DEPTH);
  localparam int CNT_W = PTR_W + 1;

  load_ctx_t        ctx_mem [PENDING_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] discard; // Flushed loads still owed a response
  logic             pop;

  assign pop = resp_valid && !flush && (discard == '0);

  assign align_valid = pop;
  assign align_ctx = ctx_mem[rd_ptr];
  assign align_data = resp_data;

  always_ff @(posedge clk) begin
    if (push_valid) begin
      ctx_mem[wr_ptr] <= push_ctx;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      discard <= '0;
    end else if (flush) begin
      // Same-cycle push and response belong to the flushed set
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      discard <= discard + count + CNT_W'(push_valid) - CNT_W'(resp_valid);
    end else begin
      if (push_valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + CNT_W'(push_valid) - CNT_W'(pop);
      if (resp_valid && discard != '0) begin
        discard <= discard - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/mem_stage.sv */
`default_nettype none

module mem_stage
  import mem_stage_pkg::*;
#(
  parameter int PENDING_DEPTH = 4
) (
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     cmd_valid,
  input  wire mem_cmd_t cmd,
  input  wire logic     flush,
  output logic          req_valid,
  output mem_req_t      req,
  input  wire logic     resp_valid,
  input  wire xlen_t    resp_data,
  output logic          wb_valid,
  output wb_t           wb
);

  logic      push_valid;
  load_ctx_t push_ctx;
  logic      align_valid;
  load_ctx_t align_ctx;
  xlen_t     align_data;

  access_issue u_issue (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .req_valid  (req_valid),
    .req        (req),
    .push_valid (push_valid),
    .push_ctx   (push_ctx)
  );

  load_tracker #(
    .PENDING_DEPTH (PENDING_DEPTH)
  ) u_tracker (
    .clk         (clk),
    .reset       (reset),
    .push_valid  (push_valid),
    .push_ctx    (push_ctx),
    .flush       (flush),
    .resp_valid  (resp_valid),
    .resp_data   (resp_data),
    .align_valid (align_valid),
    .align_ctx   (align_ctx),
    .align_data  (align_data)
  );

  load_align u_align (
    .clk         (clk),
    .reset       (reset),
    .align_valid (align_valid),
    .align_ctx   (align_ctx),
    .align_data  (align_data),
    .wb_valid    (wb_valid),
    .wb          (wb)
  );

endmodule

`default_nettype wire

/* logic/mem_stage_pkg.sv */
`default_nettype none

package mem_stage_pkg;

  localparam int XLEN = 64;
  localparam int ADDR_W = 64;
  localparam int REGNO_W = 5;
  localparam int LANE_W = 3;
  localparam int LANES = 8;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [REGNO_W-1:0] regno_t;
  typedef logic [LANE_W-1:0] lane_t; // Byte offset in a doubleword
  typedef logic [LANES-1:0] byte_mask_t;

  typedef enum logic [3:0] {
    op_none,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  // Command from execute
  typedef struct packed {
    mem_op_e op;
    addr_t   addr;       // ALU result
    xlen_t   store_data; // rs2 value
    regno_t  rd;
  } mem_cmd_t;

  typedef struct packed {
    addr_t      addr; // Doubleword aligned
    logic       write;
    byte_mask_t wmask;
    xlen_t      wdata;
  } mem_req_t;

  typedef struct packed {
    mem_op_e op;
    lane_t   lane;
    regno_t  rd;
  } load_ctx_t;

  typedef struct packed {
    regno_t rd;
    xlen_t  data;
  } wb_t;

endpackage

`default_nettype wire

/* testbench/mem_stage_sva.sv */
`default_nettype none

module mem_stage_sva
  import mem_stage_pkg::*;
#(
  parameter int PENDING_DEPTH = 4
) (
  input wire logic     clk,
  input wire logic     reset,
  input wire logic     cmd_valid,
  input wire mem_cmd_t cmd,
  input wire logic     req_valid,
  input wire logic     wb_valid,
  input wire logic     push_valid,
  input wire logic     resp_valid
);

  logic [7:0] in_flight; // Loads pushed, response not yet seen
  logic       mem_access;

  assign mem_access = cmd_valid && (cmd.op != op_none);

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= '0;
    end else begin
      in_flight <= in_flight + 8'(push_valid) - 8'(resp_valid);
    end
  end

  req_follows_cmd: assert property (@(posedge clk) disable iff (reset)
    mem_access |=> req_valid)
    else $error("no request one cycle after a load or store command");

  req_only_after_cmd: assert property (@(posedge clk) disable iff (reset)
    !mem_access |=> !req_valid)
    else $error("request without a load or store command");

  quiet_after_reset: assert property (@(posedge clk)
    reset |=> (!req_valid && !wb_valid))
    else $error("request or writeback during or right after reset");

  depth_limit: assert property (@(posedge clk) disable iff (reset)
    in_flight <= 8'(PENDING_DEPTH))
    else $error("more loads in flight than the tracker can hold");

  resp_owed: assert property (@(posedge clk) disable iff (reset)
    resp_valid |-> (in_flight != '0))
    else $error("memory response with no load outstanding");

endmodule

bind mem_stage mem_stage_sva #(
  .PENDING_DEPTH (PENDING_DEPTH)
) sva (
  .clk        (clk),
  .reset      (reset),
  .cmd_valid  (cmd_valid),
  .cmd        (cmd),
  .req_valid  (req_valid),
  .wb_valid   (wb_valid),
  .push_valid (push_valid),
  .resp_valid (resp_valid)
);

`default_nettype wire

/* testbench/tb_clock.sv */
`default_nettype none

module tb_clock #(
  parameter int PERIOD = 40
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

/* testbench/tb_memory.sv */
`default_nettype none

module tb_memory
  import mem_stage_pkg::*;
(
  input  wire logic     clk,
  input  wire logic     reset,
  input  wire logic     cmd_valid,
  input  wire mem_cmd_t cmd,
  input  wire logic     req_valid,
  input  wire mem_req_t req,
  output logic          resp_valid,
  output xlen_t         resp_data,
  output logic          exp_valid,
  output wb_t           exp_wb
);

  logic [7:0]  mem [256]; // 256-byte window
  logic [31:0] lfsr;
  mem_cmd_t    cmd_d; // Command behind the current request
  xlen_t       data_q[$];
  int          due_q[$];
  int          cycle_n;
  int          last_due;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  // Naturally aligned field, extended by op
  function automatic xlen_t expected_load(input mem_op_e op, input logic [2:0] off,
                                          input xlen_t dw);
    int         n;
    logic [2:0] lane;
    xlen_t      raw;
    logic       sext;
    n = access_bytes(op);
    lane = off & ~3'(n - 1);
    sext = (op == op_lb) || (op == op_lh) || (op == op_lw);
    raw = '0;
    for (int b = 0; b < n; b++) begin
      raw[8*b +: 8] = dw[8*(int'(lane) + b) +: 8];
    end
    if (sext && raw[8*n-1]) begin
      for (int b = n; b < 8; b++) begin
        raw[8*b +: 8] = 8'hff;
      end
    end
    return raw;
  endfunction

  initial begin
    lfsr = 32'he8563c15;
    for (int a = 0; a < 256; a++) begin
      mem[a] = 8'(rand_bits(8));
    end
    resp_valid = 1'b0;
    resp_data = '0;
    exp_valid = 1'b0;
    exp_wb = '0;
    cmd_d = '0;
    cycle_n = 0;
    last_due = -1;
  end

  always @(posedge clk) begin
    xlen_t dw;
    int    base;
    int    due;
    logic  r_valid;
    xlen_t r_data;
    logic  e_valid;
    wb_t   e_wb;
    cycle_n++;
    r_valid = 1'b0;
    r_data = '0;
    e_valid = 1'b0;
    e_wb = '0;
    if (reset) begin
      data_q.delete();
      due_q.delete();
    end else if (req_valid) begin
      base = int'(req.addr[7:3]) * 8;
      if (req.write) begin
        for (int b = 0; b < 8; b++) begin
          if (req.wmask[b]) mem[base + b] = req.wdata[8*b +: 8];
        end
      end else begin
        for (int b = 0; b < 8; b++) begin
          dw[8*b +: 8] = mem[base + b];
        end
        due = cycle_n + int'(rand_bits(3) % 6); // 1 to 6 cycles
        if (due <= last_due) due = last_due + 1; // Keep order
        last_due = due;
        data_q.push_back(dw);
        due_q.push_back(due);
        e_valid = 1'b1;
        e_wb.rd = cmd_d.rd;
        e_wb.data = expected_load(cmd_d.op, cmd_d.addr[2:0], dw);
      end
    end
    if (due_q.size() > 0 && due_q[0] == cycle_n) begin
      r_valid = 1'b1;
      r_data = data_q.pop_front();
      void'(due_q.pop_front());
    end
    if (cmd_valid) cmd_d = cmd;
    #1;
    resp_valid = r_valid;
    resp_data = r_data;
    exp_valid = e_valid;
    exp_wb = e_wb;
  end

endmodule

`default_nettype wire

/* testbench/tb_top.sv */
`default_nettype none

module tb_top
  import mem_stage_pkg::*;
;

  localparam int PENDING_DEPTH = 4;
  localparam int N_CMDS = 400;
  localparam int PERIOD = 40;
  localparam int WATCHDOG_CYCLES = N_CMDS * 10 + 200;

  logic     clk;
  logic     reset;
  logic     cmd_valid;
  mem_cmd_t cmd;
  logic     flush;
  logic     req_valid;
  mem_req_t req;
  logic     resp_valid;
  xlen_t    resp_data;
  logic     wb_valid;
  wb_t      wb;
  logic     exp_valid;
  wb_t      exp_wb;

  logic [31:0] lfsr;
  mem_req_t    req_exp_q[$];
  wb_t         value_q[$]; // Expected writeback per load, request order
  bit          kill_q[$];  // Load was flushed
  int          errors;
  int          checks;
  int          loads_sent;
  int          resps_seen;
  logic        wb_due;
  wb_t         due_wb;

  tb_clock #(.PERIOD(PERIOD)) clock_gen (.clk(clk));

  mem_stage #(.PENDING_DEPTH(PENDING_DEPTH)) uut (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .flush      (flush),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

  tb_memory memory (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .req_valid  (req_valid),
    .req        (req),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .exp_valid  (exp_valid),
    .exp_wb     (exp_wb)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  function automatic int access_bytes(input mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default: return 8;
    endcase
  endfunction

  function automatic logic is_load(input mem_op_e op);
    return (op >= op_lb) && (op <= op_ld);
  endfunction

  // Request as the memory should see it
  function automatic mem_req_t expected_request(input mem_cmd_t c);
    mem_req_t   r;
    int         n;
    logic [2:0] lane;
    n = access_bytes(c.op);
    lane = c.addr[2:0] & ~3'(n - 1);
    r.addr = {c.addr[63:3], 3'b000};
    r.write = (c.op >= op_sb);
    r.wmask = '0;
    r.wdata = '0;
    if (r.write) begin
      for (int b = 0; b < n; b++) begin
        r.wmask[int'(lane) + b] = 1'b1;
        r.wdata[8*(int'(lane) + b) +: 8] = c.store_data[8*b +: 8];
      end
    end
    return r;
  endfunction

  task automatic check_value(input string name, input xlen_t exp, input xlen_t act);
    checks++;
    assert (exp === act) else begin
      errors++;
      $display("mismatch %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_event(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("error: %s", what);
    end
  endtask

  always @(posedge clk) begin
    mem_req_t er;
    wb_t      ew;
    if (!reset) begin
      check_event(!(wb_valid && !wb_due), "writeback without a live response");
      check_event(!(wb_due && !wb_valid), "writeback missing one cycle after a response");
      if (wb_valid && wb_due) begin
        check_value("wb_rd", xlen_t'(due_wb.rd), xlen_t'(wb.rd));
        check_value("wb_data", due_wb.data, wb.data);
      end
      if (req_valid) begin
        check_event(req_exp_q.size() > 0, "request with no matching command");
        if (req_exp_q.size() > 0) begin
          er = req_exp_q.pop_front();
          check_value("req_addr", er.addr, req.addr);
          check_value("req_write", xlen_t'(er.write), xlen_t'(req.write));
          if (er.write) begin
            check_value("req_wmask", xlen_t'(er.wmask), xlen_t'(req.wmask));
            check_value("req_wdata", er.wdata, req.wdata);
          end else begin
            kill_q.push_back(1'b0);
          end
        end
      end
      if (exp_valid) value_q.push_back(exp_wb);
      if (flush) begin
        foreach (kill_q[i]) kill_q[i] = 1'b1;
      end
      wb_due = 1'b0;
      if (resp_valid) begin
        resps_seen++;
        check_event(kill_q.size() > 0 && value_q.size() > 0,
                    "response with no load outstanding");
        if (kill_q.size() > 0 && value_q.size() > 0) begin
          ew = value_q.pop_front();
          if (!kill_q.pop_front()) begin
            wb_due = 1'b1;
            due_wb = ew;
          end
        end
      end
    end
  end

  task automatic idle_cycle();
    flush = (rand_bits(4) == 0);
    @(posedge clk);
    #1;
    flush = 1'b0;
  endtask

  task automatic finish_run();
    check_event(req_exp_q.size() == 0, "commands left without a request");
    check_event(kill_q.size() == 0, "loads left without a response");
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  initial begin
    #(WATCHDOG_CYCLES * PERIOD);
    $display("watchdog expired, the run did not finish in time");
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    mem_cmd_t c;
    int       gap;
    lfsr = 32'he8563c15;
    reset = 1'b1;
    cmd_valid = 1'b1; // Load offered while in reset
    cmd = '0;
    cmd.op = op_ld;
    flush = 1'b0;
    errors = 0;
    checks = 0;
    loads_sent = 0;
    resps_seen = 0;
    wb_due = 1'b0;
    due_wb = '0;
    repeat (9) @(posedge clk);
    #1;
    cmd_valid = 1'b0;
    @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < N_CMDS; i++) begin
      gap = int'(rand_bits(2));
      for (int g = 0; g < gap; g++) idle_cycle();
      while (loads_sent - resps_seen >= PENDING_DEPTH) idle_cycle();
      c.op = mem_op_e'(4'(rand_bits(4) % 12));
      c.addr = {56'd0, 8'(rand_bits(8))};
      c.store_data = {rand_bits(32), rand_bits(32)};
      c.rd = 5'(rand_bits(5));
      cmd = c;
      cmd_valid = 1'b1;
      flush = (rand_bits(4) == 0);
      if (c.op != op_none) req_exp_q.push_back(expected_request(c));
      if (is_load(c.op)) loads_sent++;
      @(posedge clk);
      #1;
      cmd_valid = 1'b0;
      flush = 1'b0;
    end
    while (loads_sent != resps_seen) begin
      @(posedge clk);
      #1;
    end
    repeat (4) @(posedge clk);
    #1;
    finish_run();
  end

endmodule

`default_nettype wire
